// ==== flist.f ====
+incdir+verilog
verilog/i2c_master_pkg.sv
verilog/i2c_seq_ctrl.sv
verilog/i2c_bit_engine.sv
verilog/i2c_byte_shifter.sv
verilog/i2c_master_top.sv
verification/i2c_eeprom_model.sv
verification/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the I2C master testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_i2c_master \
	-f flist.f -o tb_i2c_master_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/tb_i2c_master_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$SIM_LOG"; then
	exit 1
fi
exit 0

// ==== verification/tb_i2c_master.sv ====
`timescale 1ns/100ps
`include "i2c_master_config.svh"

module tb_i2c_master;

	localparam int DONE_LIMIT = 600;

	logic                     dri_clk;
	logic                     rst_n;
	logic                     exec;
	i2c_master_pkg::i2c_req_t req;
	i2c_master_pkg::i2c_req_t req_b;
	logic [`I2C_DATA_W-1:0]   data_r;
	logic                     done;
	logic                     ack_err;
	logic                     scl;
	wire                      sda;
	logic                     nack_mode;
	logic                     busy;
	integer                   seed;
	int                       errors;
	int                       tests;
	int                       errs_before;
	int                       starts_before;
	int                       stops_before;
	int                       extra_done;
	logic [15:0]              addr;
	logic [7:0]               wdata;

	pullup (sda);

	i2c_master_top dut_i (
		.dri_clk (dri_clk),
		.rst_n   (rst_n),
		.exec    (exec),
		.req     (req),
		.data_r  (data_r),
		.done    (done),
		.ack_err (ack_err),
		.scl     (scl),
		.sda     (sda)
	);

	i2c_eeprom_model eeprom_i (
		.scl       (scl),
		.sda       (sda),
		.nack_mode (nack_mode)
	);

	initial dri_clk = 1'b0;
	always #4 dri_clk = ~dri_clk;

	task automatic log_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "failed");
		errs_before = errors;
	endtask

	function automatic bit mem_holds(input logic [15:0] a, input logic [7:0] d);
		if (!eeprom_i.mem.exists(a)) begin
			return 1'b0;
		end
		return eeprom_i.mem[a] === d;
	endfunction

	// nothing may move on an idle bus
	always @(sda or scl) begin
		if (rst_n === 1'b1 && !busy) begin
			assert (scl === 1'b1 && sda === 1'b1) else log_error("bus moved while idle");
		end
	end

	task automatic pulse_exec(input i2c_master_pkg::i2c_req_t r);
		@(posedge dri_clk);
		#1;
		req  = r;
		exec = 1'b1;
		busy = 1'b1;
		@(posedge dri_clk);
		#1;
		exec = 1'b0;
	endtask

	task automatic wait_done(input string what);
		int n;
		n = 0;
		while (!done && n < DONE_LIMIT) begin
			@(posedge dri_clk);
			#1;
			n++;
		end
		if (!done) begin
			$display("timeout: the %s never signalled done in %0d cycles", what, DONE_LIMIT);
			$display("Done: errors found");
			$finish;
		end else begin
			busy = 1'b0;
		end
	endtask

	// one start per address phase and a single stop before the bus idles high
	task automatic check_bus(input int exp_starts);
		assert (eeprom_i.start_cnt - starts_before == exp_starts &&
			eeprom_i.stop_cnt - stops_before == 1)
			else log_error($sformatf("bus had %0d starts and %0d stops",
				eeprom_i.start_cnt - starts_before, eeprom_i.stop_cnt - stops_before));
		assert (scl === 1'b1 && sda === 1'b1) else log_error("bus not high at done");
	endtask

	task automatic do_write(input logic bit16, input logic [15:0] a, input logic [7:0] d);
		i2c_master_pkg::i2c_req_t r;
		r = '{rh_wl: 1'b0, bit_ctrl: bit16, addr: a, data_w: d};
		starts_before = eeprom_i.start_cnt;
		stops_before  = eeprom_i.stop_cnt;
		pulse_exec(r);
		wait_done("write");
		check_bus(1);
	endtask

	task automatic do_read(input logic bit16, input logic [15:0] a);
		i2c_master_pkg::i2c_req_t r;
		r = '{rh_wl: 1'b1, bit_ctrl: bit16, addr: a, data_w: 8'h00};
		starts_before = eeprom_i.start_cnt;
		stops_before  = eeprom_i.stop_cnt;
		pulse_exec(r);
		wait_done("read");
		check_bus(2);
	endtask

	task automatic write_then_read(input logic bit16, input logic [15:0] a, input logic [7:0] d);
		do_write(bit16, a, d);
		assert (ack_err === 1'b0) else log_error("ack_err set on an acked write");
		assert (mem_holds(bit16 ? a : {8'h00, a[7:0]}, d))
			else log_error("model memory lacks the written byte");
		do_read(bit16, a);
		assert (ack_err === 1'b0) else log_error("ack_err set on an acked read");
		assert (data_r === d) else log_error($sformatf("data_r %02h, expected %02h", data_r, d));
	endtask

	initial begin
		seed        = 15;
		errors      = 0;
		tests       = 0;
		errs_before = 0;
		rst_n       = 1'b0;
		exec        = 1'b0;
		req         = '0;
		req_b       = '0;
		nack_mode   = 1'b0;
		busy        = 1'b0;
		repeat (8) @(posedge dri_clk);
		#1;
		rst_n = 1'b1;
		@(posedge dri_clk);
		#1;
		assert (scl === 1'b1 && sda === 1'b1 && done === 1'b0 && ack_err === 1'b0)
			else log_error("outputs not idle after reset");
		end_test("reset state");

		addr  = 16'($random(seed));
		wdata = 8'($random(seed));
		write_then_read(1'b0, addr, wdata);
		end_test("8-bit address write and read");

		addr     = 16'($random(seed));
		addr[15] = 1'b1;  // high byte must matter
		wdata    = 8'($random(seed));
		write_then_read(1'b1, addr, wdata);
		end_test("16-bit address write and read");

		nack_mode = 1'b1;
		do_write(1'b0, addr, wdata);
		assert (ack_err === 1'b1) else log_error("ack_err clear after a nacked write");
		nack_mode = 1'b0;
		do_write(1'b0, addr, wdata);
		assert (ack_err === 1'b0) else log_error("ack_err not cleared by the next request");
		end_test("nack reporting");

		addr  = 16'($random(seed));
		wdata = 8'($random(seed));
		req_b = '{rh_wl: 1'b0, bit_ctrl: 1'b1, addr: ~addr, data_w: ~wdata};
		starts_before = eeprom_i.start_cnt;
		stops_before  = eeprom_i.stop_cnt;
		pulse_exec('{rh_wl: 1'b0, bit_ctrl: 1'b1, addr: addr, data_w: wdata});
		repeat (40) @(posedge dri_clk);
		pulse_exec(req_b);  // lands mid transfer
		wait_done("write with a second exec");
		check_bus(1);
		extra_done = 0;
		for (int i = 0; i < DONE_LIMIT; i++) begin
			@(posedge dri_clk);
			#1;
			if (done) begin
				extra_done++;
			end
		end
		assert (extra_done == 0) else log_error("second done pulse after an exec while busy");
		assert (mem_holds(addr, wdata)) else log_error("first request not stored");
		end_test("exec while busy");

		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== verification/i2c_eeprom_model.sv ====
`timescale 1ns/100ps
`include "i2c_master_config.svh"

module i2c_eeprom_model (
	input  logic scl,
	inout  wire  sda,
	input  logic nack_mode
);

	typedef enum logic [2:0] {S_IDLE, S_RECV, S_ACK, S_SEND, S_MACK} slave_state_e;

	logic [7:0]   mem [logic [15:0]];
	logic [7:0]   rx_bytes [$];
	slave_state_e state = S_IDLE;
	logic [7:0]   shreg = '0;
	logic [7:0]   tx_byte = '0;
	logic [15:0]  cur_addr = '0;
	logic         drive_low = 1'b0;
	logic         first_byte = 1'b0;
	logic         rw = 1'b0;
	int           bit_cnt = 0;
	int           start_cnt = 0;
	int           stop_cnt = 0;

	assign sda = drive_low ? 1'b0 : 1'bz;

	// first byte received is the most significant
	function automatic logic [15:0] gathered_addr(input int n);
		logic [15:0] a;
		a = '0;
		for (int i = 0; i < n; i++) begin
			a = {a[7:0], rx_bytes[i]};
		end
		return a;
	endfunction

	always @(negedge sda) begin
		if (scl === 1'b1) begin  // start or repeated start
			start_cnt++;
			if (rx_bytes.size() > 0) begin
				cur_addr = gathered_addr(rx_bytes.size());  // dummy write before a read
			end
			rx_bytes.delete();
			state      = S_RECV;
			bit_cnt    = 0;
			first_byte = 1'b1;
			rw         = 1'b0;
			drive_low  = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin  // stop
			stop_cnt++;
			if (!rw && rx_bytes.size() >= 2) begin
				mem[gathered_addr(rx_bytes.size() - 1)] = rx_bytes[rx_bytes.size() - 1];
			end
			rx_bytes.delete();
			state = S_IDLE;
		end
	end

	always @(posedge scl) begin
		if (state == S_RECV && bit_cnt < 8) begin
			shreg = {shreg[6:0], sda};
			bit_cnt++;
		end else if (state == S_SEND) begin
			bit_cnt++;
		end
	end

	always @(negedge scl) begin
		#2;
		case (state)
			S_RECV: begin
				if (bit_cnt == 8) begin
					if (first_byte) begin
						first_byte = 1'b0;
						rw         = shreg[0];
						if (shreg[7:1] == `I2C_SLAVE_ADDR && !nack_mode) begin
							state = S_ACK;
						end else begin
							state = S_IDLE;  // ignore the rest of the transfer
						end
					end else begin
						rx_bytes.push_back(shreg);
						state = S_ACK;
					end
					if (state == S_ACK) begin
						#8;
						drive_low = 1'b1;  // master has let go by now
					end
				end
			end
			S_ACK: begin
				drive_low = 1'b0;
				bit_cnt   = 0;
				if (rw) begin
					tx_byte   = mem.exists(cur_addr) ? mem[cur_addr] : 8'h00;
					drive_low = !tx_byte[7];
					state     = S_SEND;
				end else begin
					state = S_RECV;
				end
			end
			S_SEND: begin
				if (bit_cnt < 8) begin
					drive_low = !tx_byte[7 - bit_cnt];
				end else begin
					drive_low = 1'b0;  // master answers the byte
					state     = S_MACK;
				end
			end
			S_MACK: state = S_IDLE;
			default: ;
		endcase
	end

endmodule

// ==== verilog/i2c_master_top.sv ====
`timescale 1ns/100ps
`include "i2c_master_config.svh"

module i2c_master_top (
	input  logic                          dri_clk,
	input  logic                          rst_n,
	input  logic                          exec,
	input  i2c_master_pkg::i2c_req_t      req,
	output logic [`I2C_DATA_W-1:0]        data_r,
	output logic                          done,
	output logic                          ack_err,
	output logic                          scl,
	inout  wire                           sda
);

	i2c_master_pkg::i2c_phase_e phase;
	i2c_master_pkg::i2c_line_t  line;
	logic                       phase_done;
	logic                       nack;
	logic                       load;
	logic [`I2C_DATA_W-1:0]     load_byte;
	logic                       shift_out;
	logic                       shift_in;
	logic                       tx_bit;
	logic [`I2C_DATA_W-1:0]     rx_byte;
	logic                       sda_in;

	// open drain, pulled up off chip
	assign sda    = line.sda_oe ? line.sda_out : 1'bz;
	assign sda_in = sda;
	assign scl    = line.scl;

	i2c_seq_ctrl seq_ctrl_i (
		.dri_clk    (dri_clk),
		.rst_n      (rst_n),
		.exec       (exec),
		.req        (req),
		.phase_done (phase_done),
		.nack       (nack),
		.rx_byte    (rx_byte),
		.phase      (phase),
		.load       (load),
		.load_byte  (load_byte),
		.data_r     (data_r),
		.done       (done),
		.ack_err    (ack_err)
	);

	i2c_bit_engine bit_engine_i (
		.dri_clk    (dri_clk),
		.rst_n      (rst_n),
		.phase      (phase),
		.tx_bit     (tx_bit),
		.sda_in     (sda_in),
		.line       (line),
		.shift_out  (shift_out),
		.shift_in   (shift_in),
		.phase_done (phase_done),
		.nack       (nack)
	);

	i2c_byte_shifter byte_shifter_i (
		.dri_clk    (dri_clk),
		.rst_n      (rst_n),
		.load       (load),
		.load_byte  (load_byte),
		.shift_out  (shift_out),
		.shift_in   (shift_in),
		.sda_in     (sda_in),
		.tx_bit     (tx_bit),
		.rx_byte    (rx_byte)
	);

endmodule

// ==== verilog/i2c_byte_shifter.sv ====
`timescale 1ns/100ps
`include "i2c_master_config.svh"

module i2c_byte_shifter (
	input  logic                   dri_clk,
	input  logic                   rst_n,
	input  logic                   load,
	input  logic [`I2C_DATA_W-1:0] load_byte,
	input  logic                   shift_out,
	input  logic                   shift_in,
	input  logic                   sda_in,
	output logic                   tx_bit,
	output logic [`I2C_DATA_W-1:0] rx_byte
);

	logic [`I2C_DATA_W-1:0] tx_sr;

	assign tx_bit = tx_sr[`I2C_DATA_W-1];  // msb first on the wire

	always_ff @(posedge dri_clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_sr <= '0;
		end else if (load) begin
			tx_sr <= load_byte;
		end else if (shift_out) begin
			tx_sr <= {tx_sr[`I2C_DATA_W-2:0], 1'b0};
		end
	end

	// read bits arrive msb first
	always_ff @(posedge dri_clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_byte <= '0;
		end else if (shift_in) begin
			rx_byte <= {rx_byte[`I2C_DATA_W-2:0], sda_in};
		end
	end

endmodule

// ==== verilog/i2c_bit_engine.sv ====
`timescale 1ns/100ps
`include "i2c_master_config.svh"

module i2c_bit_engine (
	input  logic                          dri_clk,
	input  logic                          rst_n,
	input  i2c_master_pkg::i2c_phase_e    phase,
	input  logic                          tx_bit,
	input  logic                          sda_in,
	output i2c_master_pkg::i2c_line_t     line,
	output logic                          shift_out,
	output logic                          shift_in,
	output logic                          phase_done,
	output logic                          nack
);

	localparam int CW = `I2C_PH_CNT_W;

	logic [CW-1:0] cnt;
	logic [CW-1:0] last_cnt;
	logic [CW-1:0] ofs;
	logic [CW-1:0] rel;
	logic          byte_ph;   // byte out then slave ack
	logic          in_byte;
	logic          near_end;

	always_comb begin
		last_cnt = CW'(`I2C_BYTE_LAST);
		ofs      = '0;
		byte_ph  = 1'b0;
		case (phase)
			i2c_master_pkg::PH_SLADDR, i2c_master_pkg::PH_ADDR_RD: begin
				last_cnt = CW'(`I2C_START_LAST);
				ofs      = CW'(`I2C_START_OFS);
				byte_ph  = 1'b1;
			end
			i2c_master_pkg::PH_ADDR16, i2c_master_pkg::PH_ADDR8,
			i2c_master_pkg::PH_DATA_WR: begin
				byte_ph = 1'b1;
			end
			i2c_master_pkg::PH_STOP:
				last_cnt = CW'(`I2C_STOP_HOLD + 1);
			default: ;
		endcase
	end

	assign rel      = cnt - ofs;
	assign in_byte  = (cnt >= ofs);
	assign near_end = (cnt == last_cnt - 1'b1);

	assign shift_out = byte_ph && in_byte && (rel[1:0] == 2'd0) && (rel < CW'(32));
	assign shift_in  = (phase == i2c_master_pkg::PH_DATA_RD) && (rel[1:0] == 2'd1) &&
		(rel < CW'(32));

	always_ff @(posedge dri_clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt        <= '0;
			phase_done <= 1'b0;
			nack       <= 1'b0;
			line       <= '{scl: 1'b1, sda_out: 1'b1, sda_oe: 1'b1};
		end else begin
			phase_done <= (phase != i2c_master_pkg::PH_IDLE) && near_end;
			nack       <= byte_ph && near_end && sda_in;  // high in ack slot
			if ((phase == i2c_master_pkg::PH_IDLE) || (cnt == last_cnt)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end

			case (phase)
				i2c_master_pkg::PH_IDLE: begin
					line <= '{scl: 1'b1, sda_out: 1'b1, sda_oe: 1'b1};
				end

				i2c_master_pkg::PH_STOP: begin
					case (cnt)
						CW'(0): begin
							line.sda_oe  <= 1'b1;
							line.sda_out <= 1'b0;
						end
						CW'(1): line.scl     <= 1'b1;
						CW'(3): line.sda_out <= 1'b1;  // stop
						default: ;
					endcase
				end

				i2c_master_pkg::PH_DATA_RD: begin
					if (cnt == '0) begin
						line.sda_oe <= 1'b0;  // slave drives
					end
					if (rel == CW'(32)) begin
						line.sda_oe  <= 1'b1;
						line.sda_out <= 1'b1;  // nack the last byte
					end
					if (rel[1:0] == 2'd1) begin
						line.scl <= 1'b1;
					end
					if (rel[1:0] == 2'd3) begin
						line.scl <= 1'b0;
					end
				end

				default: begin
					if (!in_byte) begin
						// start or repeated start
						case (cnt)
							CW'(0): begin
								line.sda_oe  <= 1'b1;
								line.sda_out <= 1'b1;
							end
							CW'(1): begin
								if (phase == i2c_master_pkg::PH_ADDR_RD) begin
									line.scl <= 1'b1;
								end else begin
									line.sda_out <= 1'b0;
								end
							end
							CW'(2): line.sda_out <= 1'b0;
							CW'(3): line.scl     <= 1'b0;
							default: ;
						endcase
					end else begin
						if ((rel[1:0] == 2'd0) && (rel < CW'(32))) begin
							line.sda_oe  <= 1'b1;
							line.sda_out <= tx_bit;
						end
						if (rel == CW'(32)) begin
							line.sda_oe  <= 1'b0;  // release for ack
							line.sda_out <= 1'b1;
						end
						if (rel[1:0] == 2'd1) begin
							line.scl <= 1'b1;
						end
						if (rel[1:0] == 2'd3) begin
							line.scl <= 1'b0;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== verilog/i2c_seq_ctrl.sv ====
`timescale 1ns/100ps
`include "i2c_master_config.svh"

module i2c_seq_ctrl (
	input  logic                          dri_clk,
	input  logic                          rst_n,
	input  logic                          exec,
	input  i2c_master_pkg::i2c_req_t      req,
	input  logic                          phase_done,
	input  logic                          nack,
	input  logic [`I2C_DATA_W-1:0]        rx_byte,
	output i2c_master_pkg::i2c_phase_e    phase,
	output logic                          load,
	output logic [`I2C_DATA_W-1:0]        load_byte,
	output logic [`I2C_DATA_W-1:0]        data_r,
	output logic                          done,
	output logic                          ack_err
);

	i2c_master_pkg::i2c_req_t   req_q;
	i2c_master_pkg::i2c_phase_e phase_nxt;
	logic                       phase_chg;
	logic                       accept;

	assign accept    = exec && (phase == i2c_master_pkg::PH_IDLE);
	assign phase_chg = (phase == i2c_master_pkg::PH_IDLE) ? exec : phase_done;

	// next phase, taken only on phase_chg
	always_comb begin
		phase_nxt = phase;
		case (phase)
			i2c_master_pkg::PH_IDLE:
				phase_nxt = i2c_master_pkg::PH_SLADDR;
			i2c_master_pkg::PH_SLADDR:
				phase_nxt = req_q.bit_ctrl ? i2c_master_pkg::PH_ADDR16 : i2c_master_pkg::PH_ADDR8;
			i2c_master_pkg::PH_ADDR16:
				phase_nxt = i2c_master_pkg::PH_ADDR8;
			i2c_master_pkg::PH_ADDR8:
				phase_nxt = req_q.rh_wl ? i2c_master_pkg::PH_ADDR_RD : i2c_master_pkg::PH_DATA_WR;
			i2c_master_pkg::PH_DATA_WR:
				phase_nxt = i2c_master_pkg::PH_STOP;
			i2c_master_pkg::PH_ADDR_RD:
				phase_nxt = i2c_master_pkg::PH_DATA_RD;
			i2c_master_pkg::PH_DATA_RD:
				phase_nxt = i2c_master_pkg::PH_STOP;
			default:
				phase_nxt = i2c_master_pkg::PH_IDLE;
		endcase
	end

	// byte for the shifter, loaded as the phase is entered
	always_comb begin
		load      = 1'b0;
		load_byte = '0;
		case (phase_nxt)
			i2c_master_pkg::PH_SLADDR: begin
				load      = phase_chg;
				load_byte = {`I2C_SLAVE_ADDR, 1'b0};  // write
			end
			i2c_master_pkg::PH_ADDR16: begin
				load      = phase_chg;
				load_byte = req_q.addr[15:8];
			end
			i2c_master_pkg::PH_ADDR8: begin
				load      = phase_chg;
				load_byte = req_q.addr[7:0];
			end
			i2c_master_pkg::PH_DATA_WR: begin
				load      = phase_chg;
				load_byte = req_q.data_w;
			end
			i2c_master_pkg::PH_ADDR_RD: begin
				load      = phase_chg;
				load_byte = {`I2C_SLAVE_ADDR, 1'b1};  // read
			end
			default: ;
		endcase
	end

	always_ff @(posedge dri_clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= i2c_master_pkg::PH_IDLE;
		end else if (phase_chg) begin
			phase <= phase_nxt;
		end
	end

	always_ff @(posedge dri_clk) begin
		if (accept) begin
			req_q <= req;
		end
	end

	always_ff @(posedge dri_clk or negedge rst_n) begin
		if (!rst_n) begin
			data_r  <= '0;
			done    <= 1'b0;
			ack_err <= 1'b0;
		end else begin
			done <= phase_done && (phase == i2c_master_pkg::PH_STOP);
			if (accept) begin
				ack_err <= 1'b0;
			end else if (phase_done) begin
				ack_err <= ack_err | nack;  // sticky
			end
			if (phase_done && (phase == i2c_master_pkg::PH_DATA_RD)) begin
				data_r <= rx_byte;
			end
		end
	end

endmodule

// ==== verilog/i2c_master_pkg.sv ====
`include "i2c_master_config.svh"

package i2c_master_pkg;

	// one request, captured on exec
	typedef struct packed {
		logic                   rh_wl;     // 1 = read
		logic                   bit_ctrl;  // 1 = 16-bit word address
		logic [`I2C_ADDR_W-1:0] addr;
		logic [`I2C_DATA_W-1:0] data_w;
	} i2c_req_t;

	// bus phases, in transfer order
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SLADDR,   // start + address + W
		PH_ADDR16,   // word address high byte
		PH_ADDR8,    // word address low byte
		PH_DATA_WR,
		PH_ADDR_RD,  // repeated start + address + R
		PH_DATA_RD,
		PH_STOP
	} i2c_phase_e;

	// what the master puts on the pins
	typedef struct packed {
		logic scl;
		logic sda_out;
		logic sda_oe;  // 1 = master drives sda
	} i2c_line_t;

endpackage

// ==== verilog/i2c_master_config.svh ====
`ifndef I2C_MASTER_CONFIG_SVH
`define I2C_MASTER_CONFIG_SVH

// 7-bit device address of the EEPROM
`define I2C_SLAVE_ADDR 7'b1010000

// word address and data widths
`define I2C_ADDR_W 16
`define I2C_DATA_W 8

// per-phase quarter-bit counter width
`define I2C_PH_CNT_W 7

// cycle in the stop phase where it ends
`define I2C_STOP_HOLD 15

// cycles of the byte phases, minus one
`define I2C_BYTE_LAST 35

// cycles of the phases that open with a start, minus one
`define I2C_START_LAST 39

// first data bit in a phase that opens with a start
`define I2C_START_OFS 4

`endif
